/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_video_timing
LINT_TOP   ?= video_timing_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test failed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Test completed successfully" $(LOG) || \
		{ echo "Simulation ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_video_timing.sv */
`timescale 1ns/100ps

module tb_video_timing import video_pkg::*; ();

	localparam int DEBOUNCE    = 16;
	localparam int LINE_LIMIT  = 4000;    // Longer than any line
	localparam int FRAME_LIMIT = 1200000; // Longer than any frame
	localparam int SEL_HS      = 0;
	localparam int SEL_VS      = 1;
	localparam int SEL_DE      = 2;

	// Totals are active plus front porch, sync and back porch
	localparam int HTOT_720P = int'(HPIXELS_HDTV720P) + int'(HFNPRCH_HDTV720P) +
		int'(HSYNCPW_HDTV720P) + int'(HBKPRCH_HDTV720P);
	localparam int HTOT_VGA = int'(HPIXELS_VGA) + int'(HFNPRCH_VGA) +
		int'(HSYNCPW_VGA) + int'(HBKPRCH_VGA);
	localparam int VTOT_VGA = int'(VLINES_VGA) + int'(VFNPRCH_VGA) +
		int'(VSYNCPW_VGA) + int'(VBKPRCH_VGA);
	localparam int HTOT_XGA = int'(HPIXELS_XGA) + int'(HFNPRCH_XGA) +
		int'(HSYNCPW_XGA) + int'(HBKPRCH_XGA);
	localparam int BAR_VGA = int'(HPIXELS_VGA) / 8; // Eight bars per line

	localparam logic [23:0] WHITE  = 24'hffffff;
	localparam logic [23:0] YELLOW = 24'hffff00; // Red plus green
	localparam logic [23:0] BLACK  = 24'h000000;

	logic       clk50m_bufg;
	logic       serdes_rst;
	mode_code_t sw;
	video_out_t video_out;

	integer seed;
	int     error_count;
	int     test_errors; // Count when the current test began
	int     pass_tests;
	int     fail_tests;
	int     run_len;
	int     width;
	int     period;
	int     glitch_len;

	video_timing_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE)
	) DUT (
		.clk50m_bufg(clk50m_bufg),
		.serdes_rst (serdes_rst),
		.sw         (sw),
		.video_out  (video_out)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 20 ns period

	// Outputs cleared one clock into reset
	assert property (@(posedge clk50m_bufg) serdes_rst |=>
		(video_out.de == 1'b0 && video_out.hsync == 1'b0 && video_out.vsync == 1'b0))
	else begin
		$display("MISMATCH at %0t: video_out de/hsync/vsync expected 000 got %b%b%b", $time,
			$sampled(video_out.de), $sampled(video_out.hsync), $sampled(video_out.vsync));
		error_count++;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic out_bit(input int sel);
		case (sel)
			SEL_HS:  return video_out.hsync;
			SEL_VS:  return video_out.vsync;
			default: return video_out.de;
		endcase
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Test failed");
		$finish;
	endtask

	// Falling edges for which the output holds val, 0 if it already differs
	task automatic run_length(input int sel, input logic val, input int limit,
		input string what, output int len);
		len = 0;
		while (out_bit(sel) === val) begin
			@(negedge clk50m_bufg);
			len++;
			if (len > limit)
				abort_run(what);
		end
	endtask

	task automatic measure_hsync(input logic act, output int pulse, output int per);
		int gap;
		run_length(SEL_HS, act, LINE_LIMIT, "hsync to go idle", gap); // Skip pulse in progress
		run_length(SEL_HS, !act, LINE_LIMIT, "an hsync pulse", gap);
		run_length(SEL_HS, act, LINE_LIMIT, "the end of an hsync pulse", pulse);
		run_length(SEL_HS, !act, LINE_LIMIT, "the next hsync pulse", gap);
		per = pulse + gap;
	endtask

	// Returns at the first active pixel after a fully blank line
	task automatic wait_blank_line(input int min_len);
		int len;
		int lines;
		len   = 0;
		lines = 0;
		while (len < min_len) begin
			run_length(SEL_DE, 1'b1, LINE_LIMIT, "the end of an active line", len);
			run_length(SEL_DE, 1'b0, FRAME_LIMIT, "an active line", len);
			lines++;
			if (lines > 2000)
				abort_run("a fully blank line");
		end
	endtask

	// Hsync pulses from one vsync start to the next
	task automatic count_lines(input logic act, output int lines);
		int   n;
		logic prev_h;
		logic left;
		run_length(SEL_VS, act, FRAME_LIMIT, "vsync to go idle", n);
		run_length(SEL_VS, !act, FRAME_LIMIT, "a vsync pulse", n);
		lines  = 0;
		n      = 0;
		left   = 1'b0;
		prev_h = video_out.hsync;
		while (!(left && video_out.vsync == act)) begin
			@(negedge clk50m_bufg);
			n++;
			if (n > FRAME_LIMIT)
				abort_run("the next vsync pulse");
			if (video_out.hsync == act && prev_h != act)
				lines++; // Leading edge of a pulse
			prev_h = video_out.hsync;
			if (video_out.vsync != act)
				left = 1'b1;
		end
	endtask

	task automatic check_outputs_clear();
		check_value("video_out.de", 0, int'(video_out.de));
		check_value("video_out.hsync", 0, int'(video_out.hsync));
		check_value("video_out.vsync", 0, int'(video_out.vsync));
	endtask

	task automatic end_test(input string name);
		if (error_count == test_errors) begin
			$display("%s: PASS", name);
			pass_tests++;
		end else begin
			$display("%s: FAIL with %0d errors", name, error_count - test_errors);
			fail_tests++;
		end
		test_errors = error_count;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		seed        = 71160;
		clk50m_bufg = 1'b0;
		serdes_rst  = 1'b1;
		sw          = MODE_HDTV720P; // Same as the reset mode
		error_count = 0;
		test_errors = 0;
		pass_tests  = 0;
		fail_tests  = 0;

		repeat (10) begin
			@(negedge clk50m_bufg);
			check_outputs_clear();
		end
		serdes_rst = 1'b0;
		check_outputs_clear();
		@(negedge clk50m_bufg);
		check_outputs_clear(); // First clock out of reset
		end_test("reset state");

		measure_hsync(1'b1, width, period);
		check_value("video_out.hsync period", HTOT_720P, period);
		check_value("video_out.hsync width", int'(HSYNCPW_HDTV720P), width);
		run_length(SEL_DE, 1'b1, LINE_LIMIT, "de to fall", run_len);
		run_length(SEL_DE, 1'b0, LINE_LIMIT, "de to rise", run_len);
		run_length(SEL_DE, 1'b1, LINE_LIMIT, "de to fall", run_len);
		check_value("video_out.de length", int'(HPIXELS_HDTV720P), run_len);
		end_test("720p line timing");

		sw = MODE_VGA;
		wait_blank_line(HTOT_VGA); // Only VGA vblank gets here once switched
		check_value("video_out.hsync idle", 1, int'(video_out.hsync));
		measure_hsync(1'b0, width, period);
		check_value("video_out.hsync width", int'(HSYNCPW_VGA), width);
		check_value("video_out.hsync period", HTOT_VGA, period);
		count_lines(1'b0, run_len);
		check_value("video_out.hsync pulses per frame", VTOT_VGA, run_len);
		end_test("VGA after mode change");

		// Rest of vblank still ahead
		run_length(SEL_DE, 1'b1, LINE_LIMIT, "de to fall", run_len);
		run_length(SEL_DE, 1'b0, FRAME_LIMIT, "de to rise", run_len);
		check_value("video_out.pixel", int'(WHITE), int'(video_out.pixel));
		repeat (BAR_VGA) @(negedge clk50m_bufg);
		check_value("video_out.pixel", int'(YELLOW), int'(video_out.pixel));
		repeat (6 * BAR_VGA + BAR_VGA / 2) @(negedge clk50m_bufg); // Middle of bar 7
		check_value("video_out.de", 1, int'(video_out.de));
		check_value("video_out.pixel", int'(BLACK), int'(video_out.pixel));
		end_test("colour bars");

		// Glitch sits inside the measured line, a restart would shorten it
		run_length(SEL_HS, 1'b0, LINE_LIMIT, "hsync to go idle", run_len);
		run_length(SEL_HS, 1'b1, LINE_LIMIT, "an hsync pulse", run_len);
		glitch_len = 1 + ({$random(seed)} % (DEBOUNCE - 4));
		sw = MODE_XGA;
		repeat (glitch_len) @(negedge clk50m_bufg);
		sw = MODE_VGA; // Back before the debounce ends
		run_length(SEL_HS, 1'b0, LINE_LIMIT, "the end of the hsync pulse", width);
		run_length(SEL_HS, 1'b1, LINE_LIMIT, "the next hsync pulse", period);
		check_value("video_out.hsync period", HTOT_VGA, glitch_len + width + period);
		end_test("glitch rejection");

		sw = MODE_XGA;
		wait_blank_line(HTOT_XGA);
		check_value("video_out.hsync idle", 1, int'(video_out.hsync));
		check_value("video_out.vsync idle", 1, int'(video_out.vsync));
		run_length(SEL_DE, 1'b1, LINE_LIMIT, "de to fall", run_len);
		check_value("video_out.de length", int'(HPIXELS_XGA), run_len);
		end_test("XGA polarity");

		$display("Tests passed: %0d, tests with errors: %0d", pass_tests, fail_tests);
		if (fail_tests == 0 && error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
source/video_pkg.sv
source/mode_select.sv
source/raster_counter.sv
source/bar_pattern_gen.sv
source/video_output_stage.sv
source/video_timing_top.sv
dv/tb_video_timing.sv

/* source/bar_pattern_gen.sv */
`timescale 1ns/100ps

module bar_pattern_gen import video_pkg::*; #(
	parameter int CNT_W = cnt_w
) (
	input  logic          clk50m_bufg,
	input  logic          serdes_rst,
	input  video_timing_t timing,
	input  raster_t       raster,
	output rgb_t          bar_color
);

	logic [CNT_W-1:0] pix_cnt;  // Pixel within current bar
	logic [2:0]       bar_idx;
	logic             bar_end;

	assign bar_end = (pix_cnt == CNT_W'(timing.bar_width) - 1'b1);

	// Bar stepping
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			pix_cnt <= '0;
			bar_idx <= '0;
		end else if (raster.hblnk) begin
			pix_cnt <= '0; // Line blank rearms at bar 0
			bar_idx <= '0;
		end else if (bar_end) begin
			pix_cnt <= '0;
			if (bar_idx != 3'd7)
				bar_idx <= bar_idx + 1'b1; // Stick on last bar
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// Colour lookup, one register stage
	always_ff @(posedge clk50m_bufg) begin
		if (raster.hblnk || raster.vblnk)
			bar_color <= '0; // Black in blanking
		else
			bar_color <= bar_colors[bar_idx];
	end

endmodule

/* source/mode_select.sv */
`timescale 1ns/100ps

module mode_select import video_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 50000
) (
	input  logic          clk50m_bufg,
	input  logic          serdes_rst,
	input  mode_code_t    sw,
	output video_timing_t timing,
	output logic          restart
);

	localparam int DB_W = $clog2(DEBOUNCE_CYCLES + 1);

	mode_code_t sw_meta;  // First synchronizer flop
	mode_code_t sw_sync;  // Second synchronizer flop
	mode_code_t sw_last;  // Previous synchronized sample
	mode_code_t mode_q;   // Mode in use
	logic [DB_W-1:0] stable_cnt;
	logic sw_steady;
	logic sw_new;
	logic db_done;

	////////////////////////////////////////
	// Switch synchronizer
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			sw_meta <= MODE_HDTV720P; // Matches the reset mode
			sw_sync <= MODE_HDTV720P;
			sw_last <= MODE_HDTV720P;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_last <= sw_sync;
		end
	end

	assign sw_steady = (sw_sync == sw_last);
	assign sw_new    = (sw_sync != mode_q);
	assign db_done   = (stable_cnt == DB_W'(DEBOUNCE_CYCLES - 1));

	////////////////////////////////////////
	// Debounce and mode hold
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			stable_cnt <= '0;
			mode_q     <= MODE_HDTV720P;
			timing     <= mode_timing(MODE_HDTV720P);
			restart    <= 1'b0;
		end else begin
			restart <= 1'b0; // Single cycle pulse
			if (!sw_steady || !sw_new) begin
				stable_cnt <= '0; // Bounce or nothing to change
			end else if (db_done) begin
				// Code held long enough, take it
				stable_cnt <= '0;
				mode_q     <= sw_sync;
				timing     <= mode_timing(sw_sync);
				restart    <= 1'b1;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

/* source/raster_counter.sv */
`timescale 1ns/100ps

module raster_counter import video_pkg::*; #(
	parameter int CNT_W = cnt_w
) (
	input  logic          clk50m_bufg,
	input  logic          serdes_rst,
	input  video_timing_t timing,
	input  logic          restart,
	output raster_t       raster
);

	logic [CNT_W-1:0] hcount;
	logic [CNT_W-1:0] vcount;
	logic             h_wrap;
	logic             v_wrap;

	// Last pixel of line / last line of frame
	assign h_wrap = (hcount >= CNT_W'(timing.heblnk));
	assign v_wrap = (vcount >= CNT_W'(timing.veblnk));

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hcount <= '0;
			vcount <= '0;
		end else if (restart) begin
			hcount <= '0; // New mode starts a fresh frame
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			vcount <= v_wrap ? '0 : vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	////////////////////////////////////////
	// Raw flags
	////////////////////////////////////////
	always_comb begin
		raster.hcount    = cnt_w'(hcount);
		raster.vcount    = cnt_w'(vcount);
		raster.hblnk     = (hcount > CNT_W'(timing.hsblnk));
		raster.vblnk     = (vcount > CNT_W'(timing.vsblnk));
		// Sync sits between front and back porch
		raster.hsync_int = (hcount > CNT_W'(timing.hssync)) &&
			(hcount <= CNT_W'(timing.hesync));
		raster.vsync_int = (vcount > CNT_W'(timing.vssync)) &&
			(vcount <= CNT_W'(timing.vesync));
	end

endmodule

/* source/video_output_stage.sv */
`timescale 1ns/100ps

module video_output_stage import video_pkg::*; (
	input  logic          clk50m_bufg,
	input  logic          serdes_rst,
	input  video_timing_t timing,
	input  raster_t       raster,
	input  rgb_t          bar_color,
	output video_out_t    video_out
);

	logic hsync_q;
	logic vsync_q;
	logic de_q;
	logic active;

	assign active = !raster.hblnk && !raster.vblnk;

	////////////////////////////////////////
	// Two-stage sync and DE pipeline
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hsync_q   <= 1'b0;
			vsync_q   <= 1'b0;
			de_q      <= 1'b0;
			video_out <= '0;
		end else begin
			hsync_q <= raster.hsync_int ^ timing.sync_negative; // Polarity flip
			vsync_q <= raster.vsync_int ^ timing.sync_negative;
			de_q    <= active;
			video_out.hsync <= hsync_q;
			video_out.vsync <= vsync_q;
			video_out.de    <= de_q;
			video_out.pixel <= bar_color; // Already one stage in
		end
	end

endmodule

/* source/video_pkg.sv */
package video_pkg;

////////////////////////////////////////
// Widths and mode codes
////////////////////////////////////////
localparam int cnt_w = 11; // Raster counter width

typedef logic [3:0] mode_code_t;

localparam mode_code_t MODE_VGA      = 4'b0000;
localparam mode_code_t MODE_SVGA     = 4'b0001;
localparam mode_code_t MODE_HDTV720P = 4'b0010; // Also the fallback
localparam mode_code_t MODE_XGA      = 4'b0011;
localparam mode_code_t MODE_SXGA     = 4'b1000;
localparam mode_code_t MODE_CAMERA   = 4'b1001;

////////////////////////////////////////
// Bus types
////////////////////////////////////////
typedef struct packed {
	logic [cnt_w-1:0] hsblnk;    // Last active pixel
	logic [cnt_w-1:0] hssync;    // Sync starts after this
	logic [cnt_w-1:0] hesync;    // Last sync pixel
	logic [cnt_w-1:0] heblnk;    // Last pixel of line
	logic [cnt_w-1:0] vsblnk;
	logic [cnt_w-1:0] vssync;
	logic [cnt_w-1:0] vesync;
	logic [cnt_w-1:0] veblnk;
	logic [cnt_w-1:0] bar_width; // Active width / 8
	logic             sync_negative;
} video_timing_t;

typedef struct packed {
	logic [cnt_w-1:0] hcount;
	logic [cnt_w-1:0] vcount;
	logic             hsync_int; // Raw syncs, active high
	logic             vsync_int;
	logic             hblnk;
	logic             vblnk;
} raster_t;

typedef struct packed {
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
} rgb_t;

typedef struct packed {
	logic hsync;
	logic vsync;
	logic de;
	rgb_t pixel;
} video_out_t;

// Bar order left to right
localparam rgb_t bar_colors [0:7] = '{
	'{8'hff, 8'hff, 8'hff}, // White
	'{8'hff, 8'hff, 8'h00}, // Yellow
	'{8'h00, 8'hff, 8'hff}, // Cyan
	'{8'h00, 8'hff, 8'h00}, // Green
	'{8'hff, 8'h00, 8'hff}, // Magenta
	'{8'hff, 8'h00, 8'h00}, // Red
	'{8'h00, 8'h00, 8'hff}, // Blue
	'{8'h00, 8'h00, 8'h00}  // Black
};

////////////////////////////////////////
// Format constants
////////////////////////////////////////
// 640x480
localparam logic [cnt_w-1:0] HPIXELS_VGA = 11'd640;
localparam logic [cnt_w-1:0] VLINES_VGA  = 11'd480;
localparam logic [cnt_w-1:0] HSYNCPW_VGA = 11'd96;
localparam logic [cnt_w-1:0] VSYNCPW_VGA = 11'd2;
localparam logic [cnt_w-1:0] HFNPRCH_VGA = 11'd16;
localparam logic [cnt_w-1:0] VFNPRCH_VGA = 11'd11;
localparam logic [cnt_w-1:0] HBKPRCH_VGA = 11'd48;
localparam logic [cnt_w-1:0] VBKPRCH_VGA = 11'd31;
// 800x600
localparam logic [cnt_w-1:0] HPIXELS_SVGA = 11'd800;
localparam logic [cnt_w-1:0] VLINES_SVGA  = 11'd600;
localparam logic [cnt_w-1:0] HSYNCPW_SVGA = 11'd128;
localparam logic [cnt_w-1:0] VSYNCPW_SVGA = 11'd4;
localparam logic [cnt_w-1:0] HFNPRCH_SVGA = 11'd40;
localparam logic [cnt_w-1:0] VFNPRCH_SVGA = 11'd1;
localparam logic [cnt_w-1:0] HBKPRCH_SVGA = 11'd88;
localparam logic [cnt_w-1:0] VBKPRCH_SVGA = 11'd23;
// 1024x768
localparam logic [cnt_w-1:0] HPIXELS_XGA = 11'd1024;
localparam logic [cnt_w-1:0] VLINES_XGA  = 11'd768;
localparam logic [cnt_w-1:0] HSYNCPW_XGA = 11'd136;
localparam logic [cnt_w-1:0] VSYNCPW_XGA = 11'd6;
localparam logic [cnt_w-1:0] HFNPRCH_XGA = 11'd24;
localparam logic [cnt_w-1:0] VFNPRCH_XGA = 11'd3;
localparam logic [cnt_w-1:0] HBKPRCH_XGA = 11'd160;
localparam logic [cnt_w-1:0] VBKPRCH_XGA = 11'd29;
// 1280x720
localparam logic [cnt_w-1:0] HPIXELS_HDTV720P = 11'd1280;
localparam logic [cnt_w-1:0] VLINES_HDTV720P  = 11'd720;
localparam logic [cnt_w-1:0] HSYNCPW_HDTV720P = 11'd40;
localparam logic [cnt_w-1:0] VSYNCPW_HDTV720P = 11'd5;
localparam logic [cnt_w-1:0] HFNPRCH_HDTV720P = 11'd110;
localparam logic [cnt_w-1:0] VFNPRCH_HDTV720P = 11'd5;
localparam logic [cnt_w-1:0] HBKPRCH_HDTV720P = 11'd220;
localparam logic [cnt_w-1:0] VBKPRCH_HDTV720P = 11'd20;
// 1280x1024
localparam logic [cnt_w-1:0] HPIXELS_SXGA = 11'd1280;
localparam logic [cnt_w-1:0] VLINES_SXGA  = 11'd1024;
localparam logic [cnt_w-1:0] HSYNCPW_SXGA = 11'd112;
localparam logic [cnt_w-1:0] VSYNCPW_SXGA = 11'd3;
localparam logic [cnt_w-1:0] HFNPRCH_SXGA = 11'd48;
localparam logic [cnt_w-1:0] VFNPRCH_SXGA = 11'd1;
localparam logic [cnt_w-1:0] HBKPRCH_SXGA = 11'd248;
localparam logic [cnt_w-1:0] VBKPRCH_SXGA = 11'd38;
// Camera, 720 lines with trimmed porches
localparam logic [cnt_w-1:0] HPIXELS_CAMERA = 11'd1280;
localparam logic [cnt_w-1:0] VLINES_CAMERA  = 11'd720;
localparam logic [cnt_w-1:0] HSYNCPW_CAMERA = 11'd39;
localparam logic [cnt_w-1:0] VSYNCPW_CAMERA = 11'd4;
localparam logic [cnt_w-1:0] HFNPRCH_CAMERA = 11'd110;
localparam logic [cnt_w-1:0] VFNPRCH_CAMERA = 11'd4;
localparam logic [cnt_w-1:0] HBKPRCH_CAMERA = 11'd220;
localparam logic [cnt_w-1:0] VBKPRCH_CAMERA = 11'd22;

////////////////////////////////////////
// Timing lookup
////////////////////////////////////////
// Thresholds accumulate from the last active pixel onward
function automatic video_timing_t calc_timing(
	input logic [cnt_w-1:0] hpix,
	input logic [cnt_w-1:0] hfp,
	input logic [cnt_w-1:0] hsw,
	input logic [cnt_w-1:0] hbp,
	input logic [cnt_w-1:0] vlin,
	input logic [cnt_w-1:0] vfp,
	input logic [cnt_w-1:0] vsw,
	input logic [cnt_w-1:0] vbp,
	input logic             neg
);
	video_timing_t t;
	t.hsblnk        = hpix - cnt_w'(1);
	t.hssync        = t.hsblnk + hfp;
	t.hesync        = t.hssync + hsw;
	t.heblnk        = t.hesync + hbp;
	t.vsblnk        = vlin - cnt_w'(1);
	t.vssync        = t.vsblnk + vfp;
	t.vesync        = t.vssync + vsw;
	t.veblnk        = t.vesync + vbp;
	t.bar_width     = hpix >> 3; // Eight bars per line
	t.sync_negative = neg;
	return t;
endfunction

function automatic video_timing_t mode_timing(input mode_code_t mode);
	case (mode)
		MODE_VGA: return calc_timing(HPIXELS_VGA, HFNPRCH_VGA, HSYNCPW_VGA, HBKPRCH_VGA,
			VLINES_VGA, VFNPRCH_VGA, VSYNCPW_VGA, VBKPRCH_VGA, 1'b1);
		MODE_SVGA: return calc_timing(HPIXELS_SVGA, HFNPRCH_SVGA, HSYNCPW_SVGA, HBKPRCH_SVGA,
			VLINES_SVGA, VFNPRCH_SVGA, VSYNCPW_SVGA, VBKPRCH_SVGA, 1'b0);
		MODE_XGA: return calc_timing(HPIXELS_XGA, HFNPRCH_XGA, HSYNCPW_XGA, HBKPRCH_XGA,
			VLINES_XGA, VFNPRCH_XGA, VSYNCPW_XGA, VBKPRCH_XGA, 1'b1);
		MODE_SXGA: return calc_timing(HPIXELS_SXGA, HFNPRCH_SXGA, HSYNCPW_SXGA, HBKPRCH_SXGA,
			VLINES_SXGA, VFNPRCH_SXGA, VSYNCPW_SXGA, VBKPRCH_SXGA, 1'b0);
		MODE_CAMERA: return calc_timing(HPIXELS_CAMERA, HFNPRCH_CAMERA, HSYNCPW_CAMERA,
			HBKPRCH_CAMERA, VLINES_CAMERA, VFNPRCH_CAMERA, VSYNCPW_CAMERA,
			VBKPRCH_CAMERA, 1'b0);
		default: return calc_timing(HPIXELS_HDTV720P, HFNPRCH_HDTV720P, HSYNCPW_HDTV720P,
			HBKPRCH_HDTV720P, VLINES_HDTV720P, VFNPRCH_HDTV720P, VSYNCPW_HDTV720P,
			VBKPRCH_HDTV720P, 1'b0); // 720p and unknown codes
	endcase
endfunction

endpackage

/* source/video_timing_top.sv */
`timescale 1ns/100ps

module video_timing_top import video_pkg::*; #(
	parameter int CNT_W           = cnt_w,
	parameter int DEBOUNCE_CYCLES = 50000 // About 1 ms at 50 MHz
) (
	input  logic       clk50m_bufg,
	input  logic       serdes_rst,
	input  mode_code_t sw,
	output video_out_t video_out
);

	video_timing_t timing;
	logic          restart;
	raster_t       raster;
	rgb_t          bar_color;

	// Mode switches to timing set
	mode_select #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_mode_select (
		.clk50m_bufg(clk50m_bufg),
		.serdes_rst (serdes_rst),
		.sw         (sw),
		.timing     (timing),
		.restart    (restart)
	);

	raster_counter #(
		.CNT_W(CNT_W)
	) u_raster_counter (
		.clk50m_bufg(clk50m_bufg),
		.serdes_rst (serdes_rst),
		.timing     (timing),
		.restart    (restart),
		.raster     (raster)
	);

	bar_pattern_gen #(
		.CNT_W(CNT_W)
	) u_bar_pattern_gen (
		.clk50m_bufg(clk50m_bufg),
		.serdes_rst (serdes_rst),
		.timing     (timing),
		.raster     (raster),
		.bar_color  (bar_color)
	);

	// Aligns syncs, DE and pixel
	video_output_stage u_video_output_stage (
		.clk50m_bufg(clk50m_bufg),
		.serdes_rst (serdes_rst),
		.timing     (timing),
		.raster     (raster),
		.bar_color  (bar_color),
		.video_out  (video_out)
	);

endmodule
